// File: src/posit_consts.svh
`ifndef POSIT_CONSTS_SVH
`define POSIT_CONSTS_SVH

// bits per posit word
`define POSIT_WIDTH 16

// exponent field bits
`define POSIT_ES 1

// regime count width, enough for the longest regime run
`define POSIT_RS ($clog2(`POSIT_WIDTH - 1))

// significand width with the hidden bit
`define POSIT_SIG_W (`POSIT_WIDTH - `POSIT_ES)

// product buffer entries, power of two
`define PROD_FIFO_DEPTH 4

`endif

// File: src/posit_pkg.sv
`include "posit_consts.svh"

package posit_pkg;

  // one posit word
  typedef logic [`POSIT_WIDTH-1:0] posit_t;

  // one operand after decomposition
  typedef struct packed {
    logic                    sign;
    // regime sign, 1 for a run of ones
    logic                    rgs;
    // regime magnitude |k|
    logic [`POSIT_RS-1:0]    rgm;
    logic [`POSIT_ES-1:0]    exp;
    // left aligned, hidden bit on top
    logic [`POSIT_SIG_W-1:0] sig;
    logic                    zero;
    logic                    nar;
  } posit_fields_t;

  // scale seen as regime count over exponent bits
  typedef struct packed {
    logic signed [`POSIT_RS+1:0] rgm;
    logic [`POSIT_ES-1:0]        exp;
  } posit_scale_split_t;

  // same bits as one signed power of two, k * 2^es + e
  typedef union packed {
    logic signed [`POSIT_RS+`POSIT_ES+1:0] total;
    posit_scale_split_t                    split;
  } posit_scale_u;

  // intermediate product between producer and consumer
  typedef struct packed {
    logic                      sign;
    posit_scale_u              scale;
    logic [2*`POSIT_SIG_W-1:0] sig;
    logic                      zero;
    logic                      nar;
  } posit_prod_t;

endpackage

// File: src/posit_decompose.sv
`include "posit_consts.svh"

module posit_decompose
  import posit_pkg::*;
(
  input  posit_t        i,
  output posit_fields_t fields
);

  // body is the word without its sign bit
  localparam int BW  = `POSIT_WIDTH - 1;
  localparam int RLW = `POSIT_RS + 1;

  logic           neg;
  posit_t         abs_i;
  logic [BW-1:0]  body;
  logic           run_bit;
  logic [RLW-1:0] run_len;
  logic           run_done;
  logic [RLW-1:0] k_mag;
  logic [BW-1:0]  rest;
  logic [BW-1:0]  frac;

  // ==========================================================================
  // sign handling and regime run
  // ==========================================================================

  assign neg   = i[`POSIT_WIDTH-1];
  // negative posits are decoded from their two's complement
  assign abs_i = neg ? -i : i;
  assign body  = abs_i[BW-1:0];

  // the first body bit decides the regime polarity
  assign run_bit = body[BW-1];

  // count identical leading bits from the top of the body
  always_comb begin
    run_len  = '0;
    run_done = 1'b0;
    for (int j = BW - 1; j >= 0; j--) begin
      if (!run_done && (body[j] == run_bit)) begin
        run_len = run_len + 1'b1;
      end else begin
        run_done = 1'b1;
      end
    end
  end

  // run of m ones means k = m - 1
  // run of m zeros means k = -m
  assign k_mag = run_bit ? (run_len - 1'b1) : run_len;

  // ==========================================================================
  // exponent and fraction
  // ==========================================================================

  // drop the run and its terminating bit
  assign rest = body << (run_len + 1'b1);
  // exponent bits cut off by a long regime read as zero
  assign frac = rest << `POSIT_ES;

  always_comb begin
    fields.sign = neg;
    fields.rgs  = run_bit;
    fields.rgm  = k_mag[`POSIT_RS-1:0];
    fields.exp  = rest[BW-1 -: `POSIT_ES];
    // hidden one above the fraction
    fields.sig  = {1'b1, frac[BW-1 -: `POSIT_SIG_W-1]};
    // all zeros
    fields.zero = ~|i;
    // sign bit alone
    fields.nar  = neg & ~|i[BW-1:0];
  end

endmodule

// File: src/posit_product_stage.sv
`include "posit_consts.svh"

module posit_product_stage
  import posit_pkg::*;
(
  input  logic        clk,
  input  logic        rst_n,
  input  logic        in_valid,
  input  posit_t      a,
  input  posit_t      b,
  output logic        prod_valid,
  output posit_prod_t prod
);

  localparam int SCW = `POSIT_RS + 2;
  localparam int PW  = 2 * `POSIT_SIG_W;

  posit_fields_t         fa;
  posit_fields_t         fb;
  logic signed [SCW-1:0] ka;
  logic signed [SCW-1:0] kb;
  posit_scale_u          scale_a;
  posit_scale_u          scale_b;
  posit_scale_u          scale_sum;
  logic [PW-1:0]         sig_prod;

  // ==========================================================================
  // operand decomposition
  // ==========================================================================

  posit_decompose u_dec_a (
    .i      (a),
    .fields (fa)
  );

  posit_decompose u_dec_b (
    .i      (b),
    .fields (fb)
  );

  // ==========================================================================
  // scale and significand
  // ==========================================================================

  // signed regime count from polarity and magnitude
  assign ka = fa.rgs ? SCW'(fa.rgm) : -SCW'(fa.rgm);
  assign kb = fb.rgs ? SCW'(fb.rgm) : -SCW'(fb.rgm);

  // regime over exponent reads as one signed scale
  always_comb begin
    scale_a.split.rgm = ka;
    scale_a.split.exp = fa.exp;
    scale_b.split.rgm = kb;
    scale_b.split.exp = fb.exp;
  end

  // single adder for the combined scale
  assign scale_sum.total = scale_a.total + scale_b.total;

  // full width product, value in [1,4)
  assign sig_prod = fa.sig * fb.sig;

  // ==========================================================================
  // pipeline register
  // ==========================================================================

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      prod_valid <= 1'b0;
    end else begin
      prod_valid <= in_valid;
    end
  end

  // record only moves when a pair arrives
  always_ff @(posedge clk) begin
    if (in_valid) begin
      prod.sign  <= fa.sign ^ fb.sign;
      prod.scale <= scale_sum;
      prod.sig   <= sig_prod;
      prod.zero  <= fa.zero | fb.zero;
      prod.nar   <= fa.nar | fb.nar;
    end
  end

endmodule

// File: src/posit_product_fifo.sv
`include "posit_consts.svh"

module posit_product_fifo
  import posit_pkg::*;
(
  input  logic        clk,
  input  logic        rst_n,
  input  logic        push,
  input  posit_prod_t wdata,
  input  logic        pop,
  output posit_prod_t head,
  output logic        empty,
  output logic        full,
  output logic        overflow
);

  localparam int DEPTH = `PROD_FIFO_DEPTH;
  localparam int AW    = $clog2(DEPTH);

  posit_prod_t mem [DEPTH];
  // pointers carry one wrap bit above the address
  logic [AW:0] wptr;
  logic [AW:0] rptr;
  logic        wr_en;

  // ==========================================================================
  // status
  // ==========================================================================

  // a push into a full buffer is lost
  assign wr_en = push & ~full;

  assign empty = (wptr == rptr);
  // same address, opposite wrap bit
  assign full  = (wptr[AW] != rptr[AW]) && (wptr[AW-1:0] == rptr[AW-1:0]);

  // oldest entry always presented
  assign head = mem[rptr[AW-1:0]];

  // ==========================================================================
  // pointers and sticky overflow
  // ==========================================================================

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      wptr     <= '0;
      rptr     <= '0;
      overflow <= 1'b0;
    end else begin
      if (wr_en) begin
        wptr <= wptr + 1'b1;
      end
      // consumer only pops when not empty
      if (pop) begin
        rptr <= rptr + 1'b1;
      end
      if (push && full) begin
        overflow <= 1'b1;
      end
    end
  end

  // storage
  always_ff @(posedge clk) begin
    if (wr_en) begin
      mem[wptr[AW-1:0]] <= wdata;
    end
  end

endmodule

// File: src/posit_round_encode.sv
`include "posit_consts.svh"

module posit_round_encode
  import posit_pkg::*;
(
  input  logic        clk,
  input  logic        rst_n,
  input  posit_prod_t head,
  input  logic        empty,
  input  logic        out_hold,
  output logic        pop,
  output logic        out_valid,
  output posit_t      o,
  output logic        zero,
  output logic        nar
);

  localparam int BW  = `POSIT_WIDTH - 1;
  localparam int PW  = 2 * `POSIT_SIG_W;
  localparam int SCW = `POSIT_RS + 2;
  // run fill, terminator, exponent and fraction
  localparam int LW  = BW + PW + `POSIT_ES;

  logic                  carry;
  logic [PW-1:0]         prod_n;
  posit_scale_u          scale;
  logic signed [SCW-1:0] k;
  logic                  run_bit;
  logic [SCW-1:0]        run_len;
  logic [SCW-1:0]        sh;
  logic [LW-1:0]         ext;
  logic [BW-1:0]         body;
  logic                  guard;
  logic                  round_b;
  logic                  sticky;
  logic                  ulp;
  logic                  sat_hi;
  logic                  sat_lo;
  logic [BW-1:0]         mag;
  posit_t                word;
  posit_t                result;

  // drain whenever something is queued and the sink is ready
  assign pop = ~empty & ~out_hold;

  // ==========================================================================
  // normalise
  // ==========================================================================

  // two integer digits means the scale grows by one
  assign carry  = head.sig[PW-1];
  assign prod_n = carry ? head.sig : (head.sig << 1);
  assign scale.total = head.scale.total + carry;

  // ==========================================================================
  // pack regime, exponent and fraction
  // ==========================================================================

  assign k       = scale.split.rgm;
  // k >= 0 gives a run of ones
  assign run_bit = ~k[SCW-1];
  assign run_len = run_bit ? (k + 1'b1) : -k;
  assign sh      = SCW'(BW) - run_len;

  // beyond the longest regime the result clamps
  assign sat_hi = (k > (BW - 1));
  assign sat_lo = (k < -(BW - 1));

  // shifting left trims the fill down to the run length
  assign ext = {{BW{run_bit}}, ~run_bit, scale.split.exp, prod_n[PW-2:0]} << sh;

  assign body    = ext[LW-1 -: BW];
  assign guard   = ext[LW-BW-1];
  assign round_b = ext[LW-BW-2];
  assign sticky  = |ext[LW-BW-3:0];

  // ==========================================================================
  // round to nearest even
  // ==========================================================================

  // ties go to an even last bit
  // a full run of ones leaves a zero terminator as guard, so maxpos never rounds up
  assign ulp = guard & (round_b | sticky | body[0]);

  always_comb begin
    if (sat_hi) begin
      // maxpos
      mag = '1;
    end else if (sat_lo) begin
      // minpos, never zero
      mag = {{(BW-1){1'b0}}, 1'b1};
    end else begin
      mag = body + ulp;
    end
  end

  assign word = {1'b0, mag};

  // specials override, NaR first
  always_comb begin
    if (head.nar) begin
      result = {1'b1, {BW{1'b0}}};
    end else if (head.zero) begin
      result = '0;
    end else if (head.sign) begin
      result = -word;
    end else begin
      result = word;
    end
  end

  // ==========================================================================
  // output register
  // ==========================================================================

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      out_valid <= 1'b0;
    end else begin
      out_valid <= pop;
    end
  end

  always_ff @(posedge clk) begin
    if (pop) begin
      o    <= result;
      zero <= head.zero & ~head.nar;
      nar  <= head.nar;
    end
  end

endmodule

// File: src/posit_mul_unit.sv
`include "posit_consts.svh"

module posit_mul_unit
  import posit_pkg::*;
(
  input  logic   clk,
  input  logic   rst_n,
  input  logic   in_valid,
  input  posit_t a,
  input  posit_t b,
  input  logic   out_hold,
  output logic   out_valid,
  output posit_t o,
  output logic   zero,
  output logic   nar,
  output logic   full,
  output logic   overflow
);

  // producer to buffer
  logic        prod_valid;
  posit_prod_t prod;

  // buffer to consumer
  posit_prod_t head;
  logic        empty;
  logic        pop;

  // ==========================================================================
  // producer, buffer, consumer
  // ==========================================================================

  posit_product_stage u_product (
    .clk        (clk),
    .rst_n      (rst_n),
    .in_valid   (in_valid),
    .a          (a),
    .b          (b),
    .prod_valid (prod_valid),
    .prod       (prod)
  );

  posit_product_fifo u_fifo (
    .clk      (clk),
    .rst_n    (rst_n),
    .push     (prod_valid),
    .wdata    (prod),
    .pop      (pop),
    .head     (head),
    .empty    (empty),
    .full     (full),
    .overflow (overflow)
  );

  posit_round_encode u_encode (
    .clk       (clk),
    .rst_n     (rst_n),
    .head      (head),
    .empty     (empty),
    .out_hold  (out_hold),
    .pop       (pop),
    .out_valid (out_valid),
    .o         (o),
    .zero      (zero),
    .nar       (nar)
  );

endmodule

// File: tb/posit_mul_model.svh
`ifndef POSIT_MUL_MODEL_SVH
`define POSIT_MUL_MODEL_SVH

// real value of a posit word, zero and NaR handled by the caller
function automatic real decode_value(input posit_t p);
  posit_t v;
  int     idx;
  int     run;
  int     k;
  int     e;
  int     s;
  int     j;
  real    f;
  real    w;
  v   = p[`POSIT_WIDTH-1] ? -p : p;
  idx = `POSIT_WIDTH - 2;
  run = 0;
  // leading run of identical bits below the sign
  while ((idx >= 0) && (v[idx] == v[`POSIT_WIDTH-2])) begin
    run++;
    idx--;
  end
  k = v[`POSIT_WIDTH-2] ? (run - 1) : -run;
  // terminating bit of the run
  idx--;
  e = 0;
  for (j = 0; j < `POSIT_ES; j++) begin
    e = 2 * e + ((idx >= 0) ? int'(v[idx]) : 0);
    idx--;
  end
  f = 1.0;
  w = 0.5;
  while (idx >= 0) begin
    if (v[idx]) f = f + w;
    w = w / 2.0;
    idx--;
  end
  s = k * (1 << `POSIT_ES) + e;
  while (s > 0) begin
    f = f * 2.0;
    s--;
  end
  while (s < 0) begin
    f = f / 2.0;
    s++;
  end
  return p[`POSIT_WIDTH-1] ? -f : f;
endfunction

// nearest posit by rounding the infinite bit pattern, ties to even
function automatic posit_t encode_nearest(input real x);
  logic                    neg;
  real                     f;
  int                      s;
  int                      k;
  int                      e;
  int                      len;
  int                      shift;
  int                      j;
  longint unsigned         pat;
  longint unsigned         rem;
  longint unsigned         half;
  logic [`POSIT_WIDTH-2:0] body;
  posit_t                  word;
  neg = (x < 0.0);
  f   = neg ? -x : x;
  s   = 0;
  // split into 2^s times a value in [1,2)
  while (f >= 2.0) begin
    f = f / 2.0;
    s++;
  end
  while (f < 1.0) begin
    f = f * 2.0;
    s--;
  end
  k = s >>> `POSIT_ES;
  e = s - k * (1 << `POSIT_ES);
  if (k >= `POSIT_WIDTH - 1) begin
    // clamp at maxpos
    body = '1;
  end else if (k < -(`POSIT_WIDTH - 2)) begin
    // regime run longer than the body, clamp at minpos, never zero
    body = 1;
  end else begin
    if (k >= 0) begin
      // k+1 ones then a zero
      pat = ((64'd1 << (k + 1)) - 64'd1) << 1;
      len = k + 2;
    end else begin
      // -k zeros then a one
      pat = 64'd1;
      len = 1 - k;
    end
    pat = (pat << `POSIT_ES) | longint'(e);
    f   = f - 1.0;
    // product fractions fit in twice the significand width
    for (j = 0; j < 2 * `POSIT_SIG_W; j++) begin
      f   = f * 2.0;
      pat = pat << 1;
      if (f >= 1.0) begin
        pat = pat | 64'd1;
        f   = f - 1.0;
      end
    end
    len   = len + `POSIT_ES + 2 * `POSIT_SIG_W;
    shift = len - (`POSIT_WIDTH - 1);
    body  = (`POSIT_WIDTH-1)'(pat >> shift);
    rem   = pat & ((64'd1 << shift) - 64'd1);
    half  = 64'd1 << (shift - 1);
    if ((rem > half) || ((rem == half) && body[0])) begin
      body = body + 1'b1;
    end
  end
  word = {1'b0, body};
  return neg ? -word : word;
endfunction

// expected {nar, zero, o} for one operand pair
function automatic logic [`POSIT_WIDTH+1:0] expected_product(input posit_t pa, input posit_t pb);
  posit_t nar_word;
  nar_word = {1'b1, {(`POSIT_WIDTH-1){1'b0}}};
  if ((pa == nar_word) || (pb == nar_word)) begin
    return {1'b1, 1'b0, nar_word};
  end else if ((pa == '0) || (pb == '0)) begin
    return {1'b0, 1'b1, {`POSIT_WIDTH{1'b0}}};
  end
  return {1'b0, 1'b0, encode_nearest(decode_value(pa) * decode_value(pb))};
endfunction

`endif

// File: tb/posit_mul_unit_tb.sv
`include "posit_consts.svh"

module posit_mul_unit_tb
  import posit_pkg::*;
();

  localparam int W       = `POSIT_WIDTH;
  localparam int DEPTH   = `PROD_FIFO_DEPTH;
  localparam int NUM_DIR = 23;
  localparam int NUM_RND = 200;
  // buffer fill, one lost pair, one pair after release
  localparam int NUM_BP  = DEPTH + 2;
  localparam int LIMIT   = 4 * (NUM_DIR + NUM_RND + NUM_BP) + 50;
  localparam logic [31:0] SEED = 32'hf424_7d1a;

  // one directed vector, result as {nar, zero, o}
  typedef struct packed {
    logic   hold;
    posit_t a;
    posit_t b;
    logic   nar;
    logic   zero;
    posit_t o;
  } vector_t;

  logic   clk;
  logic   rst_n;
  logic   in_valid;
  posit_t a;
  posit_t b;
  logic   out_hold;
  logic   out_valid;
  posit_t o;
  logic   zero;
  logic   nar;
  logic   full;
  logic   overflow;

  vector_t      vectors [NUM_DIR];
  logic [W+1:0] exp_q [$];
  logic [W+1:0] mon_exp;
  logic [31:0]  seed;
  logic [31:0]  rnd;
  posit_t       ra;
  posit_t       rb;
  int           error_count = 0;
  int           cycle_count = 0;

  `include "posit_mul_model.svh"

  posit_mul_unit dut0 (
    .clk       (clk),
    .rst_n     (rst_n),
    .in_valid  (in_valid),
    .a         (a),
    .b         (b),
    .out_hold  (out_hold),
    .out_valid (out_valid),
    .o         (o),
    .zero      (zero),
    .nar       (nar),
    .full      (full),
    .overflow  (overflow)
  );

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  // ==========================================================================
  // checking helpers
  // ==========================================================================

  task automatic check_value(input string name, input logic [31:0] got, input logic [31:0] exp);
    if (got !== exp) begin
      error_count++;
      $display("[ERROR] %s: got 0x%h, expected 0x%h", name, got, exp);
      $display("Simulation failed");
      $fatal(1, "stopping at the first mismatch");
    end
  endtask

  task automatic report_failure(input string msg);
    error_count++;
    $display("%s", msg);
    $display("Simulation failed");
    $fatal(1, "stopping at the first failure");
  endtask

  // run limit from the number of vectors
  always @(posedge clk) begin
    cycle_count = cycle_count + 1;
    if (cycle_count > LIMIT) begin
      report_failure("timeout, the run went past its cycle limit");
    end
  end

  // scoreboard, results leave in issue order
  always @(negedge clk) begin
    if (rst_n && out_valid) begin
      if (exp_q.size() == 0) begin
        report_failure("output strobe seen with no result pending");
      end else begin
        mon_exp = exp_q.pop_front();
        check_value("o", o, mon_exp[W-1:0]);
        check_value("zero", zero, mon_exp[W]);
        check_value("nar", nar, mon_exp[W+1]);
      end
    end
  end

  // ==========================================================================
  // stimulus helpers
  // ==========================================================================

  task automatic apply_reset();
    rst_n    = 1'b0;
    in_valid = 1'b0;
    repeat (5) @(posedge clk);
    #1;
    rst_n = 1'b1;
  endtask

  // pair held for one cycle, result queued unless the pair should be lost
  task automatic apply_pair(input posit_t pa, input posit_t pb, input logic [W+1:0] res,
                            input bit keep);
    a        = pa;
    b        = pb;
    in_valid = 1'b1;
    if (keep) begin
      exp_q.push_back(res);
    end
    @(posedge clk);
    #1;
    in_valid = 1'b0;
  endtask

  task automatic wait_drain();
    while (exp_q.size() != 0) begin
      @(posedge clk);
      #1;
    end
  endtask

  // edges from the sampling edge to the output strobe
  task automatic check_latency();
    int cnt;
    cnt = 0;
    while (!out_valid && (cnt < 8)) begin
      @(posedge clk);
      #1;
      cnt++;
    end
    if (!out_valid) begin
      report_failure("no output strobe within 8 cycles of the input");
    end else begin
      check_value("latency", cnt, 2);
    end
  endtask

  task automatic load_vectors();
    // identities and signs
    vectors[0]  = {1'b0, 16'h4000, 16'h4000, 1'b0, 1'b0, 16'h4000};
    vectors[1]  = {1'b0, 16'h4000, 16'h5800, 1'b0, 1'b0, 16'h5800};
    vectors[2]  = {1'b0, 16'h5800, 16'h4000, 1'b0, 1'b0, 16'h5800};
    vectors[3]  = {1'b0, 16'h3000, 16'hc000, 1'b0, 1'b0, 16'hd000};
    vectors[4]  = {1'b0, 16'h6000, 16'hc000, 1'b0, 1'b0, 16'ha000};
    vectors[5]  = {1'b0, 16'h5800, 16'hc000, 1'b0, 1'b0, 16'ha800};
    vectors[6]  = {1'b0, 16'hb000, 16'hc000, 1'b0, 1'b0, 16'h5000};
    // exact products and rounding
    vectors[7]  = {1'b0, 16'h4800, 16'h5000, 1'b0, 1'b0, 16'h5800};
    vectors[8]  = {1'b0, 16'h4800, 16'h4800, 1'b0, 1'b0, 16'h5200};
    vectors[9]  = {1'b0, 16'h4001, 16'h4001, 1'b0, 1'b0, 16'h4002};
    // tie with odd last bit rounds up
    vectors[10] = {1'b0, 16'h4800, 16'h4001, 1'b0, 1'b0, 16'h4802};
    // zero and NaR
    vectors[11] = {1'b0, 16'h0000, 16'h5800, 1'b0, 1'b1, 16'h0000};
    vectors[12] = {1'b0, 16'h5800, 16'h0000, 1'b0, 1'b1, 16'h0000};
    vectors[13] = {1'b0, 16'h8000, 16'h4000, 1'b1, 1'b0, 16'h8000};
    vectors[14] = {1'b0, 16'h8000, 16'h0000, 1'b1, 1'b0, 16'h8000};
    vectors[15] = {1'b0, 16'h0000, 16'h8000, 1'b1, 1'b0, 16'h8000};
    // saturation at maxpos and minpos
    vectors[16] = {1'b0, 16'h7fff, 16'h6000, 1'b0, 1'b0, 16'h7fff};
    vectors[17] = {1'b0, 16'h7fff, 16'h7fff, 1'b0, 1'b0, 16'h7fff};
    vectors[18] = {1'b0, 16'h0001, 16'h2000, 1'b0, 1'b0, 16'h0001};
    vectors[19] = {1'b0, 16'h0001, 16'hc000, 1'b0, 1'b0, 16'hffff};
    // short hold, then release
    vectors[20] = {1'b1, 16'h5000, 16'h5000, 1'b0, 1'b0, 16'h6000};
    vectors[21] = {1'b1, 16'h3000, 16'h3000, 1'b0, 1'b0, 16'h2000};
    vectors[22] = {1'b0, 16'h4000, 16'h7fff, 1'b0, 1'b0, 16'h7fff};
  endtask

  // ==========================================================================
  // test sequence
  // ==========================================================================

  initial begin
    rst_n    = 1'b0;
    in_valid = 1'b0;
    a        = '0;
    b        = '0;
    out_hold = 1'b0;
    seed     = SEED;
    rnd      = $urandom(seed);
    load_vectors();
    apply_reset();
    check_value("out_valid", out_valid, 1'b0);
    check_value("full", full, 1'b0);
    check_value("overflow", overflow, 1'b0);

    // directed table, latency checked from an empty buffer
    for (int i = 0; i < NUM_DIR; i++) begin
      out_hold = vectors[i].hold;
      if (!vectors[i].hold) begin
        wait_drain();
        apply_pair(vectors[i].a, vectors[i].b,
                   {vectors[i].nar, vectors[i].zero, vectors[i].o}, 1'b1);
        check_latency();
      end else begin
        apply_pair(vectors[i].a, vectors[i].b,
                   {vectors[i].nar, vectors[i].zero, vectors[i].o}, 1'b1);
        check_value("out_valid", out_valid, 1'b0);
      end
    end
    wait_drain();

    // back to back random pairs
    out_hold = 1'b0;
    for (int i = 0; i < NUM_RND; i++) begin
      rnd = $urandom();
      ra  = rnd[W-1:0];
      rnd = $urandom();
      rb  = rnd[W-1:0];
      apply_pair(ra, rb, expected_product(ra, rb), 1'b1);
    end
    wait_drain();

    // fill the buffer while the sink holds
    out_hold = 1'b1;
    for (int i = 0; i < DEPTH; i++) begin
      rnd = $urandom();
      ra  = rnd[W-1:0];
      rb  = 16'h4800;
      apply_pair(ra, rb, expected_product(ra, rb), 1'b1);
      check_value("out_valid", out_valid, 1'b0);
    end
    @(posedge clk);
    #1;
    check_value("full", full, 1'b1);
    check_value("overflow", overflow, 1'b0);
    check_value("out_valid", out_valid, 1'b0);

    // this pair finds the buffer full and is lost
    apply_pair(16'h5000, 16'h5000, '0, 1'b0);
    @(posedge clk);
    #1;
    check_value("overflow", overflow, 1'b1);
    check_value("out_valid", out_valid, 1'b0);

    // release and drain in order
    out_hold = 1'b0;
    wait_drain();
    check_value("full", full, 1'b0);
    check_value("overflow", overflow, 1'b1);
    apply_pair(16'h4800, 16'h4800, expected_product(16'h4800, 16'h4800), 1'b1);
    wait_drain();
    check_value("overflow", overflow, 1'b1);

    // only reset clears the sticky flag
    apply_reset();
    check_value("overflow", overflow, 1'b0);
    check_value("full", full, 1'b0);
    check_value("out_valid", out_valid, 1'b0);

    if (error_count == 0) begin
      $display("Simulation completed successfully");
      $finish;
    end else begin
      $display("Simulation failed");
      $fatal(1, "errors were recorded");
    end
  end

endmodule

// File: posit_mul_unit.f
+incdir+src
+incdir+tb
src/posit_pkg.sv
src/posit_decompose.sv
src/posit_product_stage.sv
src/posit_product_fifo.sv
src/posit_round_encode.sv
src/posit_mul_unit.sv
tb/posit_mul_unit_tb.sv
